// ==== Bender.yml ====
package:
  name: ram_1r1w

sources:
  # Packages first, then interfaces and modules
  - logic/ram_cfg_pkg.sv
  - logic/ram_types_pkg.sv
  - logic/ram_port_if.sv
  - logic/delay_valid.sv
  - logic/ram_flops_1r1w.sv
  - logic/ram_1r1w_top.sv

  # Testbench only in simulation
  - target: simulation
    files:
      - sim/ram_tb.sv

// ==== logic/delay_valid.sv ====
`timescale 1ns/1ps

module delay_valid #(
  parameter int Width     = 1,
  parameter int NumStages = 1
) (
  input  logic             wr_clk,
  input  logic             wr_rst,
  input  logic             in_valid,
  input  logic [Width-1:0] in,
  output logic             out_valid,
  output logic [Width-1:0] out
);

  if (NumStages == 0) begin : gen_wire

    // No stages, straight pass
    assign out_valid = in_valid;
    assign out       = in;

  end else begin : gen_stages

    // Stage s holds what entered s+1 edges ago
    logic [NumStages-1:0] valid_q;
    logic [Width-1:0]     data_q [NumStages];

    // ----------------------------------------
    // Valid chain
    // ----------------------------------------
    always_ff @(posedge wr_clk) begin
      if (wr_rst) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= in_valid;
        for (int s = 1; s < NumStages; s++) begin
          valid_q[s] <= valid_q[s-1];
        end
      end
    end

    // ----------------------------------------
    // Data chain
    // ----------------------------------------
    // Each stage loads only behind a valid, otherwise it holds
    always_ff @(posedge wr_clk) begin
      if (in_valid) begin
        data_q[0] <= in;
      end
      for (int s = 1; s < NumStages; s++) begin
        if (valid_q[s-1]) begin
          data_q[s] <= data_q[s-1];
        end
      end
    end

    assign out_valid = valid_q[NumStages-1];
    assign out       = data_q[NumStages-1];

    // Valid leaves exactly NumStages edges after it entered
    valid_delay_a : assert property (@(posedge wr_clk) disable iff (wr_rst)
      !wr_rst |-> ##NumStages (out_valid == $past(in_valid, NumStages)));

  end

endmodule

// ==== logic/ram_1r1w_top.sv ====
`timescale 1ns/1ps

module ram_1r1w_top import ram_types_pkg::*; (
  input  logic     wr_clk,
  input  logic     wr_rst,
  // Write port
  input  logic     wr_valid,
  input  addr_t    wr_addr,
  input  entry_u   wr_data,
  input  word_en_t wr_word_en,
  // Read port
  input  logic     rd_addr_valid,
  input  addr_t    rd_addr,
  output logic     rd_data_valid,
  output entry_u   rd_data
);

  // ----------------------------------------
  // Port bundles
  // ----------------------------------------
  ram_wr_if wr_bus ();
  ram_rd_if rd_bus ();

  // Write side, plain pins onto the src end
  assign wr_bus.wr_valid   = wr_valid;
  assign wr_bus.wr_addr    = wr_addr;
  assign wr_bus.wr_data    = wr_data;
  assign wr_bus.wr_word_en = wr_word_en;

  // Read request onto the req end
  assign rd_bus.rd_addr_valid = rd_addr_valid;
  assign rd_bus.rd_addr       = rd_addr;

  // Returned data back out to the pins
  assign rd_data_valid = rd_bus.rd_data_valid;
  assign rd_data       = rd_bus.rd_data;

  // ----------------------------------------
  // RAM core
  // ----------------------------------------
  // Both ports share wr_clk so the same-cycle bypass is legal
  ram_flops_1r1w core (
    .wr_clk(wr_clk),
    .wr_rst(wr_rst),
    .wr    (wr_bus.dst),
    .rd    (rd_bus.mem)
  );

endmodule

// ==== logic/ram_cfg_pkg.sv ====
package ram_cfg_pkg;

  // ----------------------------------------
  // Array geometry
  // ----------------------------------------

  // Number of entries in the array
  localparam int depth = 16;

  // Bits per entry
  localparam int width = 32;

  // Smallest unit a partial write can replace
  localparam int word_width = 8;

  // Partial-write words per entry, one enable bit each
  localparam int num_words = width / word_width;

  // Entry address bits
  localparam int addr_width = $clog2(depth);

  // ----------------------------------------
  // Pipeline stages
  // ----------------------------------------

  // Registers on both the write and the read address paths
  // Equal counts keep the same-cycle bypass aligned
  localparam int addr_stages = 1;

  // Registers after the array read mux
  localparam int rd_data_stages = 1;

  // Cycles from read issue to rd_data_valid
  localparam int read_latency = addr_stages + rd_data_stages;

  // Cycles from write issue until the array holds the new value
  localparam int write_latency = addr_stages + 1;

endpackage

// ==== logic/ram_flops_1r1w.sv ====
`timescale 1ns/1ps

module ram_flops_1r1w import ram_cfg_pkg::*; import ram_types_pkg::*; (
  input logic   wr_clk,
  input logic   wr_rst,
  ram_wr_if.dst wr,
  ram_rd_if.mem rd
);

  // Write path word is {addr, data, word_en}
  logic [addr_width+width+num_words-1:0] wr_path_in;
  logic [addr_width+width+num_words-1:0] wr_path_out;

  // Write port as seen at the array
  logic     mem_wr_valid;
  addr_t    mem_wr_addr;
  entry_u   mem_wr_data;
  word_en_t mem_wr_word_en;

  // Read port as seen at the array
  logic     mem_rd_addr_valid;
  addr_t    mem_rd_addr;
  entry_u   mem_rd_stored;
  entry_u   mem_rd_data;
  logic     mem_rd_hit;

  entry_u   mem [depth];

  // Old entry with the enabled lanes taken from the new data
  function automatic entry_u merge_words(entry_u old_e, entry_u new_e, word_en_t en);
    entry_u res;
    res = old_e;
    for (int w = 0; w < num_words; w++) begin
      if (en[w]) begin
        res.words[w] = new_e.words[w];
      end
    end
    return res;
  endfunction

  // True when every enabled lane of got equals exp
  function automatic bit words_match(entry_u got, entry_u exp, word_en_t en);
    bit ok;
    ok = 1'b1;
    for (int w = 0; w < num_words; w++) begin
      if (en[w] && (got.words[w] != exp.words[w])) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // ----------------------------------------
  // Address pipelines
  // ----------------------------------------
  // Word enable rides with the address and data
  assign wr_path_in = {wr.wr_addr, wr.wr_data, wr.wr_word_en};

  delay_valid #(
    .Width    (addr_width + width + num_words),
    .NumStages(addr_stages)
  ) wr_path (
    .wr_clk   (wr_clk),
    .wr_rst   (wr_rst),
    .in_valid (wr.wr_valid),
    .in       (wr_path_in),
    .out_valid(mem_wr_valid),
    .out      (wr_path_out)
  );

  assign {mem_wr_addr, mem_wr_data, mem_wr_word_en} = wr_path_out;

  // Same stage count as the write side so a same-edge pair meets at the array
  delay_valid #(
    .Width    (addr_width),
    .NumStages(addr_stages)
  ) rd_addr_path (
    .wr_clk   (wr_clk),
    .wr_rst   (wr_rst),
    .in_valid (rd.rd_addr_valid),
    .in       (rd.rd_addr),
    .out_valid(mem_rd_addr_valid),
    .out      (mem_rd_addr)
  );

  // ----------------------------------------
  // Array
  // ----------------------------------------
  // All entries clear on reset, then masked writes
  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;
      end
    end else if (mem_wr_valid) begin
      mem[mem_wr_addr] <= merge_words(mem[mem_wr_addr], mem_wr_data, mem_wr_word_en);
    end
  end

  // ----------------------------------------
  // Read mux and bypass
  // ----------------------------------------
  assign mem_rd_stored = mem[mem_rd_addr];

  // Write landing this edge on the entry being read
  assign mem_rd_hit = mem_wr_valid && mem_rd_addr_valid && (mem_wr_addr == mem_rd_addr);

  // Hit returns what the entry holds after this edge, lane by lane
  assign mem_rd_data = mem_rd_hit ?
                       merge_words(mem_rd_stored, mem_wr_data, mem_wr_word_en) :
                       mem_rd_stored;

  delay_valid #(
    .Width    (width),
    .NumStages(rd_data_stages)
  ) rd_data_path (
    .wr_clk   (wr_clk),
    .wr_rst   (wr_rst),
    .in_valid (mem_rd_addr_valid),
    .in       (mem_rd_data),
    .out_valid(rd.rd_data_valid),
    .out      (rd.rd_data)
  );

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // Every read returns at fixed latency
  read_latency_a : assert property (@(posedge wr_clk) disable iff (wr_rst)
    rd.rd_addr_valid |-> ##read_latency rd.rd_data_valid);

  // Same-edge write and read to one entry returns the new lanes
  rw_hazard_new_data_a : assert property (@(posedge wr_clk) disable iff (wr_rst)
    wr.wr_valid && rd.rd_addr_valid && (wr.wr_addr == rd.rd_addr) |->
      ##read_latency rd.rd_data_valid &&
      words_match(rd.rd_data, $past(wr.wr_data, read_latency),
                  $past(wr.wr_word_en, read_latency)));

  // Array holds the written lanes write_latency edges after issue
  write_lands_a : assert property (@(posedge wr_clk) disable iff (wr_rst)
    wr.wr_valid |-> ##write_latency
      words_match(mem[$past(wr.wr_addr, write_latency)],
                  $past(wr.wr_data, write_latency),
                  $past(wr.wr_word_en, write_latency)));

endmodule

// ==== logic/ram_port_if.sv ====
`timescale 1ns/1ps

// Write port bundle, valid strobe with no back-pressure
interface ram_wr_if import ram_types_pkg::*; ();

  logic     wr_valid;
  addr_t    wr_addr;
  entry_u   wr_data;
  // Lanes to replace, other lanes keep their value
  word_en_t wr_word_en;

  // Requester side
  modport src(output wr_valid, wr_addr, wr_data, wr_word_en);
  // Memory side
  modport dst(input wr_valid, wr_addr, wr_data, wr_word_en);

endinterface

// Read port bundle, address goes in and data comes back at fixed latency
interface ram_rd_if import ram_types_pkg::*; ();

  logic   rd_addr_valid;
  addr_t  rd_addr;
  // Single-cycle strobe per issued read
  logic   rd_data_valid;
  entry_u rd_data;

  // Requester side issues addresses and takes data
  modport req(output rd_addr_valid, rd_addr, input rd_data_valid, rd_data);
  // Memory side takes addresses and returns data
  modport mem(input rd_addr_valid, rd_addr, output rd_data_valid, rd_data);

endinterface

// ==== logic/ram_types_pkg.sv ====
package ram_types_pkg;

  import ram_cfg_pkg::*;

  // ----------------------------------------
  // Port types
  // ----------------------------------------

  // Entry address
  typedef logic [addr_width-1:0] addr_t;

  // One bit per partial-write word, bit 0 covers the low byte
  typedef logic [num_words-1:0] word_en_t;

  // ----------------------------------------
  // Entry view
  // ----------------------------------------

  // Same 32 bits seen as one word or as byte lanes
  // The lane view lines up with word_en_t for masked writes and bypass merges
  typedef union packed {
    // Whole entry
    logic [width-1:0] full;
    // Byte lanes, lane 0 in the low byte
    logic [num_words-1:0][word_width-1:0] words;
  } entry_u;

endpackage

// ==== project.f ====
logic/ram_cfg_pkg.sv
logic/ram_types_pkg.sv
logic/ram_port_if.sv
logic/delay_valid.sv
logic/ram_flops_1r1w.sv
logic/ram_1r1w_top.sv
sim/ram_tb.sv

// ==== sim/ram_tb.sv ====
`timescale 1ns/1ps

module ram_tb import ram_cfg_pkg::*; import ram_types_pkg::*; ();

  // ----------------------------------------
  // Run length and watchdog
  // ----------------------------------------
  localparam int reset_cycles  = 5;
  localparam int random_cycles = 400;
  // Idle edges a drain may wait for the last reads
  localparam int drain_cycles  = read_latency + 3;
  // Reset, directed ops, random traffic, and five drains
  localparam int total_cycles  = reset_cycles + 16 + 32 + 48 + 8 + random_cycles
                                 + 5 * (drain_cycles + 2);
  localparam int timeout_ns    = (total_cycles + 20) * 8;

  logic     wr_clk;
  logic     wr_rst;
  logic     wr_valid;
  addr_t    wr_addr;
  entry_u   wr_data;
  word_en_t wr_word_en;
  logic     rd_addr_valid;
  addr_t    rd_addr;
  logic     rd_data_valid;
  entry_u   rd_data;

  // Reference model and expected returns, oldest first
  entry_u      model [depth];
  entry_u      exp_q [$];
  int          issue_q [$];
  int          cycle = 0;
  int          n_issued = 0;
  int          n_returned = 0;
  int          data_errs = 0;
  int          timing_errs = 0;
  int          proto_errs = 0;
  logic [31:0] rng_state = 32'hf50e;

  ram_1r1w_top dut (
    .wr_clk       (wr_clk),
    .wr_rst       (wr_rst),
    .wr_valid     (wr_valid),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .wr_word_en   (wr_word_en),
    .rd_addr_valid(rd_addr_valid),
    .rd_addr      (rd_addr),
    .rd_data_valid(rd_data_valid),
    .rd_data      (rd_data)
  );

  initial begin
    wr_clk = 1'b0;
    forever #4 wr_clk = ~wr_clk;
  end

  // Edge counter, every process sees the pre-edge value
  always @(posedge wr_clk) cycle <= cycle + 1;

  // ----------------------------------------
  // Reference and helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Enabled byte lanes come from the new data, the rest stay
  function automatic entry_u apply_write(entry_u old_e, entry_u new_e, word_en_t en);
    logic [width-1:0] mask;
    entry_u           res;
    mask = '0;
    for (int w = 0; w < num_words; w++) begin
      mask[w*word_width +: word_width] = {word_width{en[w]}};
    end
    res.full = (old_e.full & ~mask) | (new_e.full & mask);
    return res;
  endfunction

  task automatic check_entry(input entry_u got, input entry_u exp);
    if (got.full !== exp.full) begin
      $display("Mismatch rd_data got %h expected %h at cycle %0d", got.full, exp.full, cycle);
      data_errs++;
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch rd_data_valid count got %h expected %h", got, exp);
      proto_errs++;
    end
  endtask

  // One issue edge, write goes into the model before the read is sampled
  task automatic drive_cycle(input logic do_wr, input addr_t wa, input entry_u wd,
                             input word_en_t we, input logic do_rd, input addr_t ra);
    @(posedge wr_clk);
    wr_valid      <= do_wr;
    wr_addr       <= wa;
    wr_data       <= wd;
    wr_word_en    <= we;
    rd_addr_valid <= do_rd;
    rd_addr       <= ra;
    if (do_wr) begin
      model[wa] = apply_write(model[wa], wd, we);
    end
    if (do_rd) begin
      exp_q.push_back(model[ra]);
      issue_q.push_back(cycle);
      n_issued++;
    end
  endtask

  // Idle the ports, then wait for outstanding reads with a bound
  task automatic drain_reads();
    int waited;
    drive_cycle(1'b0, '0, '0, '0, 1'b0, '0);
    waited = 0;
    @(negedge wr_clk);
    while (exp_q.size() != 0 && waited < drain_cycles) begin
      @(negedge wr_clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Reads still outstanding after the drain window: %0d left", exp_q.size());
      proto_errs++;
    end
  endtask

  // ----------------------------------------
  // Compare process
  // ----------------------------------------
  always @(posedge wr_clk) begin : compare_returns
    entry_u exp_e;
    int     issued;
    int     lat;
    if (!wr_rst && rd_data_valid) begin
      n_returned++;
      if (exp_q.size() == 0) begin
        $display("Unexpected rd_data_valid with no read outstanding at cycle %0d", cycle);
        proto_errs++;
      end else begin
        exp_e  = exp_q.pop_front();
        issued = issue_q.pop_front();
        check_entry(rd_data, exp_e);
        // Strobe was set on the previous edge
        lat = cycle - 1 - issued;
        if (lat > read_latency) begin
          $display("Read issued at cycle %0d returned late after %0d cycles", issued, lat);
          timing_errs++;
        end else if (lat < read_latency) begin
          $display("Read issued at cycle %0d returned early after %0d cycles", issued, lat);
          timing_errs++;
        end
      end
    end
  end

  // ----------------------------------------
  // Watchdog
  // ----------------------------------------
  initial begin : watchdog
    #(timeout_ns * 1ns);
    $display("Timeout after %0d ns with the test sequence still running", timeout_ns);
    $display("Errors data %0d timing %0d protocol %0d", data_errs, timing_errs, proto_errs);
    $display("TEST FAILED");
    $finish;
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : main_seq
    entry_u      wd;
    word_en_t    we;
    addr_t       wa;
    addr_t       ra;
    logic [31:0] r;
    wr_rst        = 1'b1;
    wr_valid      = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    wr_word_en    = '0;
    rd_addr_valid = 1'b0;
    rd_addr       = '0;
    for (int i = 0; i < depth; i++) begin
      model[i] = '0;
    end
    repeat (reset_cycles) @(posedge wr_clk);
    wr_rst <= 1'b0;

    // Cleared array reads back zero
    for (int a = 0; a < depth; a++) begin
      drive_cycle(1'b0, '0, '0, '0, 1'b1, addr_t'(a));
    end
    drain_reads();

    // Full writes everywhere, then read back
    for (int a = 0; a < depth; a++) begin
      wd.full = 32'h9e37_79b9 * (a + 1);
      drive_cycle(1'b1, addr_t'(a), wd, '1, 1'b0, '0);
    end
    for (int a = 0; a < depth; a++) begin
      drive_cycle(1'b0, '0, '0, '0, 1'b1, addr_t'(a));
    end
    drain_reads();

    // Single-lane writes, then mixed masks, zero mask included
    for (int a = 0; a < depth; a++) begin
      wd.full = 32'h7f4a_7c15 ^ (a * 32'h0101_0101);
      we = word_en_t'(1 << (a % num_words));
      drive_cycle(1'b1, addr_t'(a), wd, we, 1'b0, '0);
    end
    for (int a = 0; a < depth; a++) begin
      wd.full = 32'hc2b2_ae35 + (a << 4);
      we = word_en_t'(a) ^ 4'b1010;
      drive_cycle(1'b1, addr_t'(a), wd, we, 1'b0, '0);
    end
    for (int a = 0; a < depth; a++) begin
      drive_cycle(1'b0, '0, '0, '0, 1'b1, addr_t'(a));
    end
    drain_reads();

    // Read one edge early sees old data, same edge sees the merge
    for (int k = 0; k < 4; k++) begin
      wa = addr_t'(4 * k + 3);
      wd.full = 32'h1234_5678 ^ (k * 32'h1111_1111);
      we = k[0] ? 4'b0110 : 4'b1111;
      drive_cycle(1'b0, '0, '0, '0, 1'b1, wa);
      drive_cycle(1'b1, wa, wd, we, 1'b1, wa);
    end
    drain_reads();

    // Random back-to-back traffic, reads weighted above writes
    for (int i = 0; i < random_cycles; i++) begin
      rng_state = xorshift32(rng_state);
      r = rng_state;
      rng_state = xorshift32(rng_state);
      wd.full = rng_state;
      wa = r[7:4];
      // Force an address match now and then to hit the bypass
      ra = (r[12] && r[13]) ? r[7:4] : r[11:8];
      we = r[19:16];
      drive_cycle(r[0], wa, wd, we, r[1] | r[2], ra);
    end
    drain_reads();

    check_count(n_returned, n_issued);

    $display("Errors data %0d timing %0d protocol %0d", data_errs, timing_errs, proto_errs);
    if (data_errs + timing_errs + proto_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
